/* logic/ara_defines.svh */
//////////////////////////////////////////////////
// Vector unit configuration
// Lane count, element width and result latency
//////////////////////////////////////////////////

`ifndef ARA_DEFINES_SVH
`define ARA_DEFINES_SVH

// Number of parallel lanes
`define ARA_NR_LANES 4

// Element width in bits
`define ARA_ELEN 16

// Cycles from accepted instruction to result
// One for the lanes, one for the merge
`define ARA_LATENCY 2

`endif

/* logic/ara_pkg.sv */
//////////////////////////////////////////////////
// Vector unit types
// Element, whole vector, per-lane mask and the
// operation codes shared by all blocks
//////////////////////////////////////////////////

`include "ara_defines.svh"

package ara_pkg;

  // One vector element
  typedef logic [`ARA_ELEN-1:0] elem_t;

  // Whole vector with lane 0 in the low bits
  typedef logic [`ARA_NR_LANES*`ARA_ELEN-1:0] vec_t;

  // One bit per lane
  typedef logic [`ARA_NR_LANES-1:0] lane_mask_t;

  // Operation codes
  typedef enum logic [2:0] {
    VOP_ADD   = 3'd0,  // wrapping vs2 + vs1
    VOP_SUB   = 3'd1,  // wrapping vs2 - vs1
    VOP_AND   = 3'd2,
    VOP_OR    = 3'd3,
    VOP_XOR   = 3'd4,
    VOP_SADDU = 3'd5   // clamps to all ones
  } vop_e;

endpackage : ara_pkg

/* logic/lane_alu.sv */
//////////////////////////////////////////////////
// Lane array
// Element-wise arithmetic and logic over all
// lanes in parallel, one register stage with a
// saturation bit per lane
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_defines.svh"

module lane_alu import ara_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  vop_e       op_i,
  input  vec_t       vs1_i,
  input  vec_t       vs2_i,
  output vec_t       alu_result_o,
  output lane_mask_t alu_sat_o,
  output logic       alu_valid_o
);

  vec_t       result_d;
  lane_mask_t sat_d;

  //////////////////////////////////////////////////
  // Lanes

  for (genvar l = 0; l < `ARA_NR_LANES; l++) begin : gen_lane
    elem_t              op_a;
    elem_t              op_b;
    logic [`ARA_ELEN:0] sum;
    elem_t              res;
    logic               sat;

    assign op_a = vs2_i[l*`ARA_ELEN +: `ARA_ELEN];
    assign op_b = vs1_i[l*`ARA_ELEN +: `ARA_ELEN];

    // Extra bit keeps the carry for saturation
    assign sum = {1'b0, op_a} + {1'b0, op_b};

    always_comb begin
      sat = 1'b0;
      case (op_i)
        VOP_ADD: res = sum[`ARA_ELEN-1:0];
        VOP_SUB: res = op_a - op_b;
        VOP_AND: res = op_a & op_b;
        VOP_OR:  res = op_a | op_b;
        VOP_XOR: res = op_a ^ op_b;
        VOP_SADDU: begin
          // Carry out means the sum passed all ones
          res = sum[`ARA_ELEN] ? '1 : sum[`ARA_ELEN-1:0];
          sat = sum[`ARA_ELEN];
        end
        default: res = '0;
      endcase
    end

    assign result_d[l*`ARA_ELEN +: `ARA_ELEN] = res;
    assign sat_d[l]                           = sat;
  end : gen_lane

  //////////////////////////////////////////////////
  // Output stage

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= valid_i;
    end
  end

  // Payload only moves with an instruction
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      alu_result_o <= result_d;
      alu_sat_o    <= sat_d;
    end
  end

  a_op_defined: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |-> op_i inside {VOP_ADD, VOP_SUB, VOP_AND, VOP_OR, VOP_XOR, VOP_SADDU})
    else $error("lane_alu: undefined operation code %0d", op_i);

endmodule : lane_alu

/* logic/mask_unit.sv */
//////////////////////////////////////////////////
// Mask unit
// Turns mask and unmasked flag into per-element
// write enables and holds the old destination
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mask_unit import ara_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  logic       vm_i,
  input  lane_mask_t mask_i,
  input  vec_t       vd_old_i,
  output lane_mask_t wr_en_o,
  output vec_t       vd_keep_o,
  output logic       mask_valid_o
);

  lane_mask_t wr_en_d;

  // Unmasked instructions write every element
  assign wr_en_d = vm_i ? '1 : mask_i;

  // Valid strobe runs beside the lane array
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_valid_o <= 1'b0;
    end else begin
      mask_valid_o <= valid_i;
    end
  end

  // Enables and undisturbed destination
  // Held while the pipeline is idle
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      wr_en_o   <= wr_en_d;
      vd_keep_o <= vd_old_i;
    end
  end

endmodule : mask_unit

/* logic/result_merge.sv */
//////////////////////////////////////////////////
// Result merge
// Writes active elements with the lane result and
// keeps the old destination elsewhere
// Sticky saturation flag from active lanes only
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_defines.svh"

module result_merge import ara_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       alu_valid_i,
  input  logic       mask_valid_i,
  input  vec_t       alu_result_i,
  input  lane_mask_t alu_sat_i,
  input  lane_mask_t wr_en_i,
  input  vec_t       vd_keep_i,
  input  logic       vxsat_clr_i,
  output vec_t       result_o,
  output logic       result_valid_o,
  output logic       vxsat_o
);

  vec_t merged;
  logic sat_set;

  // Per element select
  for (genvar l = 0; l < `ARA_NR_LANES; l++) begin : gen_elem
    assign merged[l*`ARA_ELEN +: `ARA_ELEN] = wr_en_i[l] ?
                                              alu_result_i[l*`ARA_ELEN +: `ARA_ELEN] :
                                              vd_keep_i[l*`ARA_ELEN +: `ARA_ELEN];
  end : gen_elem

  // Only active lanes of a live instruction count
  assign sat_set = alu_valid_i & (|(alu_sat_i & wr_en_i));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_o       <= '0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= alu_valid_i;
      if (alu_valid_i) begin
        result_o <= merged;
      end
    end
  end

  // Set beats clear on the same edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vxsat_o <= 1'b0;
    end else if (sat_set) begin
      vxsat_o <= 1'b1;
    end else if (vxsat_clr_i) begin
      vxsat_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // Both side units see the same instructions
  a_valid_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    alu_valid_i == mask_valid_i)
    else $error("result_merge: lane and mask valid out of step");

  a_sat_needs_insn: assert property (@(posedge clk_i) disable iff (reset_i)
    !alu_valid_i |=> !$rose(vxsat_o))
    else $error("result_merge: vxsat rose without an instruction");

endmodule : result_merge

/* logic/ara_top.sv */
//////////////////////////////////////////////////
// Vector unit top level
// Lane array and mask unit side by side, feeding
// the result merge. Two cycles per instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ara_top import ara_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  // Instruction
  input  logic       valid_i,
  input  vop_e       op_i,
  input  vec_t       vs1_i,
  input  vec_t       vs2_i,
  input  vec_t       vd_old_i,
  input  lane_mask_t mask_i,
  input  logic       vm_i,
  // Saturation flag
  input  logic       vxsat_clr_i,
  output logic       vxsat_o,
  // Result
  output vec_t       result_o,
  output logic       result_valid_o
);

  vec_t       alu_result;
  lane_mask_t alu_sat;
  logic       alu_valid;
  lane_mask_t wr_en;
  vec_t       vd_keep;
  logic       mask_valid;

  //////////////////////////////////////////////////
  // Execute stage

  lane_alu i_lane_alu (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .valid_i     (valid_i   ),
    .op_i        (op_i      ),
    .vs1_i       (vs1_i     ),
    .vs2_i       (vs2_i     ),
    .alu_result_o(alu_result),
    .alu_sat_o   (alu_sat   ),
    .alu_valid_o (alu_valid )
  );

  mask_unit i_mask_unit (
    .clk_i       (clk_i     ),
    .reset_i     (reset_i   ),
    .valid_i     (valid_i   ),
    .vm_i        (vm_i      ),
    .mask_i      (mask_i    ),
    .vd_old_i    (vd_old_i  ),
    .wr_en_o     (wr_en     ),
    .vd_keep_o   (vd_keep   ),
    .mask_valid_o(mask_valid)
  );

  //////////////////////////////////////////////////
  // Merge stage

  result_merge i_result_merge (
    .clk_i         (clk_i         ),
    .reset_i       (reset_i       ),
    .alu_valid_i   (alu_valid     ),
    .mask_valid_i  (mask_valid    ),
    .alu_result_i  (alu_result    ),
    .alu_sat_i     (alu_sat       ),
    .wr_en_i       (wr_en         ),
    .vd_keep_i     (vd_keep       ),
    .vxsat_clr_i   (vxsat_clr_i   ),
    .result_o      (result_o      ),
    .result_valid_o(result_valid_o),
    .vxsat_o       (vxsat_o       )
  );

endmodule : ara_top

/* dv/ara_tb.sv */
//////////////////////////////////////////////////
// Vector unit testbench
// Random and directed instructions into ara_top,
// queue-based reference model, checks done by
// concurrent assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ara_defines.svh"

module ara_tb import ara_pkg::*; ();

  typedef struct packed {
    vec_t vec;
    logic vm;
    logic sat;  // overflow in an active lane
    logic ovf;  // overflow in any lane
  } exp_t;

  logic       clk_i;
  logic       reset_i;
  logic       valid_i;
  vop_e       op_i;
  vec_t       vs1_i;
  vec_t       vs2_i;
  vec_t       vd_old_i;
  lane_mask_t mask_i;
  logic       vm_i;
  logic       vxsat_clr_i;
  vec_t       result_o;
  logic       result_valid_o;
  logic       vxsat_o;

  integer     seed = 24;
  int         check_errors = 0;
  int         timeout_errors = 0;
  exp_t       exp_q[$];
  exp_t       cur;
  logic       model_vxsat = 1'b0;
  logic       seen_valid = 1'b0;

  ara_top DUT (
    .clk_i         (clk_i         ),
    .reset_i       (reset_i       ),
    .valid_i       (valid_i       ),
    .op_i          (op_i          ),
    .vs1_i         (vs1_i         ),
    .vs2_i         (vs2_i         ),
    .vd_old_i      (vd_old_i      ),
    .mask_i        (mask_i        ),
    .vm_i          (vm_i          ),
    .vxsat_clr_i   (vxsat_clr_i   ),
    .vxsat_o       (vxsat_o       ),
    .result_o      (result_o      ),
    .result_valid_o(result_valid_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic flag_error(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    check_errors++;
  endtask

  //////////////////////////////////////////////////
  // Reference model

  function automatic exp_t predict(vop_e op, logic vm, lane_mask_t mask,
                                   vec_t vs1, vec_t vs2, vec_t old);
    exp_t        e;
    elem_t       a;
    elem_t       b;
    elem_t       r;
    int unsigned sum;
    int unsigned elem_max;
    logic        active;
    e = '0;
    e.vm = vm;
    elem_max = 2**`ARA_ELEN - 1;
    for (int l = 0; l < `ARA_NR_LANES; l++) begin
      a = vs2[l*`ARA_ELEN +: `ARA_ELEN];
      b = vs1[l*`ARA_ELEN +: `ARA_ELEN];
      sum = 32'(a) + 32'(b);
      active = vm | mask[l];
      case (op)
        VOP_ADD:   r = elem_t'(sum);
        VOP_SUB:   r = a - b;
        VOP_AND:   r = a & b;
        VOP_OR:    r = a | b;
        VOP_XOR:   r = a ^ b;
        VOP_SADDU: r = (sum > elem_max) ? '1 : elem_t'(sum);
        default:   r = '0;
      endcase
      if (op == VOP_SADDU && sum > elem_max) begin
        e.ovf = 1'b1;
        e.sat = e.sat | active;
      end
      e.vec[l*`ARA_ELEN +: `ARA_ELEN] = active ? r : old[l*`ARA_ELEN +: `ARA_ELEN];
    end
    return e;
  endfunction

  function automatic vec_t splat(elem_t e);
    vec_t v;
    for (int l = 0; l < `ARA_NR_LANES; l++) begin
      v[l*`ARA_ELEN +: `ARA_ELEN] = e;
    end
    return v;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int l = 0; l < `ARA_NR_LANES; l++) begin
      v[l*`ARA_ELEN +: `ARA_ELEN] = elem_t'($random(seed));
    end
    return v;
  endfunction

  // Next falling edge; fold in what the DUT did at the last rising edge
  task automatic step();
    logic set_now;
    @(negedge clk_i);
    set_now = 1'b0;
    if (result_valid_o) begin
      if (exp_q.size() == 0) begin
        flag_error("result_valid_o high with no instruction in flight");
      end else begin
        cur = exp_q.pop_front();
        set_now = cur.sat;
      end
    end
    if (reset_i) model_vxsat = 1'b0;
    else if (set_now) model_vxsat = 1'b1;
    else if (vxsat_clr_i) model_vxsat = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks

  task automatic send(vop_e op, logic vm, lane_mask_t mask, vec_t vs1, vec_t vs2, vec_t old);
    step();
    valid_i     = 1'b1;
    op_i        = op;
    vm_i        = vm;
    mask_i      = mask;
    vs1_i       = vs1;
    vs2_i       = vs2;
    vd_old_i    = old;
    vxsat_clr_i = 1'b0;
    seen_valid  = 1'b1;
    exp_q.push_back(predict(op, vm, mask, vs1, vs2, old));
  endtask

  task automatic send_random(logic vm);
    logic [31:0] r;
    r = $unsigned($random(seed)) % 6;
    send(vop_e'(r[2:0]), vm, lane_mask_t'($random(seed)), rand_vec(), rand_vec(), rand_vec());
  endtask

  task automatic idle();
    step();
    valid_i     = 1'b0;
    vxsat_clr_i = 1'b0;
  endtask

  task automatic clear_sat();
    step();
    valid_i     = 1'b0;
    vxsat_clr_i = 1'b1;
    idle();
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      idle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out waiting for result_valid_o, %0d results missing", exp_q.size());
      timeout_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Checks

  a_reset_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !seen_valid |-> !result_valid_o && !vxsat_o)
    else flag_error("result_valid_o or vxsat_o high before any instruction");

  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o == $past(valid_i, `ARA_LATENCY))
    else flag_error("result_valid_o not aligned with valid_i");

  a_unmasked: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && cur.vm |-> result_o == cur.vec)
    else flag_error("unmasked result differs from model");

  a_masked: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && !cur.vm |-> result_o == cur.vec)
    else flag_error("masked result differs from model");

  a_sat_set: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && cur.sat |-> vxsat_o)
    else flag_error("vxsat_o not set by active saturation");

  a_sat_masked_off: assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && cur.ovf && !cur.sat && !$past(vxsat_clr_i) |->
    vxsat_o == $past(vxsat_o))
    else flag_error("vxsat_o changed by masked-off overflow");

  a_sat_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    vxsat_o == model_vxsat)
    else flag_error("vxsat_o differs from sticky model");

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    op_i        = VOP_ADD;
    vs1_i       = '0;
    vs2_i       = '0;
    vd_old_i    = '0;
    mask_i      = '0;
    vm_i        = 1'b1;
    vxsat_clr_i = 1'b0;
    repeat (10) idle();
    reset_i = 1'b0;
    repeat (4) idle();

    // Back-to-back unmasked burst
    repeat (12) send_random(1'b1);
    wait_results();

    // Masked instructions with random gaps
    for (int i = 0; i < 30; i++) begin
      send_random(1'b0);
      if ($random(seed) & 1) idle();
    end
    wait_results();
    clear_sat();

    // Overflow only in inactive lanes
    send(VOP_SADDU, 1'b0, lane_mask_t'(1), splat(elem_t'(16'h0020)),
         (splat(elem_t'(16'hFFF0)) << `ARA_ELEN) | vec_t'(16'h0001), rand_vec());
    wait_results();

    // Active overflow, then flag holds until cleared
    send(VOP_SADDU, 1'b1, '0, splat(elem_t'(16'h0020)), splat(elem_t'(16'hFFF0)), rand_vec());
    repeat (6) send(VOP_ADD, 1'b1, '0, rand_vec(), rand_vec(), rand_vec());
    wait_results();
    repeat (3) idle();
    clear_sat();
    repeat (4) idle();

    $display("Error counts: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : ara_tb

/* compile.f */
+incdir+logic
logic/ara_pkg.sv
logic/lane_alu.sv
logic/mask_unit.sv
logic/result_merge.sv
logic/ara_top.sv
dv/ara_tb.sv

/* run.sh */
#!/bin/sh
# Build the vector unit testbench with Verilator and run it
# Exit status follows the pass line in the simulation output

verilator --binary --timing --assert -f compile.f \
  --top-module ara_tb -o ara_sim \
  && ./obj_dir/ara_sim | tee /dev/stderr \
  | grep -q "Simulation finished: PASS" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
